// File: Bender.yml
package:
  name: gte_cpu_port

sources:
  - logic/gtePkg.sv
  - logic/gteRegFile.sv
  - logic/gteLeadCount.sv
  - logic/gteShadowRegs.sv
  - logic/gteReadMux.sv
  - logic/gteCpuPort.sv
  - target: simulation
    files:
      - tb/gteChecker.sv
      - tb/gte_asserts.sv
      - tb/gteTb.sv

// File: files.f
logic/gtePkg.sv
logic/gteRegFile.sv
logic/gteLeadCount.sv
logic/gteShadowRegs.sv
logic/gteReadMux.sv
logic/gteCpuPort.sv
tb/gteChecker.sv
tb/gte_asserts.sv
tb/gteTb.sv

// File: logic/gteCpuPort.sv
module gteCpuPort (
	input  logic            i_clk,
	input  logic            resetStatus,
	input  gtePkg::cpuReq_t i_req,
	output gtePkg::word_t   o_dataOut
);
	import gtePkg::*;

	// --------------------------------------------------------------------
	// Request decode, bit 5 picks the file
	// --------------------------------------------------------------------
	logic        isCtrl;
	logic        dataRd, ctrlRd;
	logic        dataWr, ctrlWr;
	word_t       dataFileOut;    // Data file read port
	word_t       ctrlFileOut;    // Control file read port
	shadowView_t view;           // Registers outside the files

	assign isCtrl = i_req.id[5];
	assign dataRd = i_req.rd & ~isCtrl;
	assign ctrlRd = i_req.rd &  isCtrl;
	assign dataWr = i_req.wr & ~isCtrl;   // Shadow IDs also land in the file
	assign ctrlWr = i_req.wr &  isCtrl;

	gteRegFile dataFile (
		.i_clk    (i_clk),
		.i_rd     (dataRd),
		.i_rdAdr  (i_req.id[4:0]),
		.o_rdData (dataFileOut),
		.i_wr     (dataWr),
		.i_wrAdr  (i_req.id[4:0]),
		.i_wrData (i_req.data)
	);

	gteRegFile ctrlFile (
		.i_clk    (i_clk),
		.i_rd     (ctrlRd),
		.i_rdAdr  (i_req.id[4:0]),
		.o_rdData (ctrlFileOut),
		.i_wr     (ctrlWr),
		.i_wrAdr  (i_req.id[4:0]),
		.i_wrData (i_req.data)
	);

	gteShadowRegs shadowRegs (
		.i_clk       (i_clk),
		.resetStatus (resetStatus),
		.i_req       (i_req),
		.o_view      (view)
	);

	gteReadMux readMux (
		.i_clk       (i_clk),
		.resetStatus (resetStatus),
		.i_req       (i_req),
		.i_dataFile  (dataFileOut),
		.i_ctrlFile  (ctrlFileOut),
		.i_view      (view),
		.o_dataOut   (o_dataOut)
	);

endmodule

// File: logic/gteLeadCount.sv
module gteLeadCount (
	input  gtePkg::word_t    i_value,
	output gtePkg::leadCnt_t o_count
);
	import gtePkg::*;

	logic [30:0] diffBits;   // Set where a bit differs from bit 31
	leadCnt_t    runLen;     // Equal bits below the sign, 0..31

	assign diffBits = i_value[30:0] ^ {31{i_value[31]}};

	// Scan down from bit 30, stop at first difference
	always_comb begin : runScan
		logic stop;
		runLen = '0;
		stop   = 1'b0;
		for (int i = 30; i >= 0; i--) begin
			if (diffBits[i]) begin
				stop = 1'b1;
			end else if (!stop) begin
				runLen = runLen + leadCnt_t'(1);
			end
		end
	end

	assign o_count = runLen + leadCnt_t'(1);   // Sign bit counts too

endmodule

// File: logic/gtePkg.sv
package gtePkg;

	// --------------------------------------------------------------------
	// Widths
	// --------------------------------------------------------------------
	typedef logic [31:0] word_t;     // CPU register word
	typedef logic [15:0] half_t;     // IR, SX, SY, SZ
	typedef logic [5:0]  regId_t;    // Bit 5 selects control side
	typedef logic [4:0]  regAdr_t;   // Address inside one file
	typedef logic [5:0]  leadCnt_t;  // 1..32

	// CPU request, one strobe per cycle at most
	typedef struct packed {
		logic   rd;
		logic   wr;
		regId_t id;
		word_t  data;
	} cpuReq_t;

	// Registers held outside the files
	typedef struct packed {
		half_t [3:0] ir;
		half_t [2:0] sx;     // SXY FIFO, X half
		half_t [2:0] sy;     // SXY FIFO, Y half
		half_t [3:0] sz;
		word_t [2:0] rgb;
		leadCnt_t    lzcr;   // Count taken at LZCS write
	} shadowView_t;

	// --------------------------------------------------------------------
	// Register IDs
	// --------------------------------------------------------------------
	localparam regId_t REG_VZ0  = 6'd1;
	localparam regId_t REG_VZ1  = 6'd3;
	localparam regId_t REG_VZ2  = 6'd5;
	localparam regId_t REG_OTZ  = 6'd7;
	localparam regId_t REG_IR0  = 6'd8;
	localparam regId_t REG_IR1  = 6'd9;
	localparam regId_t REG_IR2  = 6'd10;
	localparam regId_t REG_IR3  = 6'd11;
	localparam regId_t REG_SXY0 = 6'd12;
	localparam regId_t REG_SXY1 = 6'd13;
	localparam regId_t REG_SXY2 = 6'd14;
	localparam regId_t REG_SXP  = 6'd15;   // Write pushes the FIFO
	localparam regId_t REG_SZ0  = 6'd16;
	localparam regId_t REG_SZ1  = 6'd17;
	localparam regId_t REG_SZ2  = 6'd18;
	localparam regId_t REG_SZ3  = 6'd19;
	localparam regId_t REG_RGB0 = 6'd20;
	localparam regId_t REG_RGB1 = 6'd21;
	localparam regId_t REG_RGB2 = 6'd22;
	localparam regId_t REG_IRGB = 6'd28;
	localparam regId_t REG_ORGB = 6'd29;
	localparam regId_t REG_LZCS = 6'd30;
	localparam regId_t REG_LZCR = 6'd31;
	localparam regId_t REG_R33  = 6'd36;   // Control side from here
	localparam regId_t REG_L33  = 6'd44;
	localparam regId_t REG_LB3  = 6'd52;
	localparam regId_t REG_H    = 6'd58;
	localparam regId_t REG_ZSF4 = 6'd62;

endpackage

// File: logic/gteReadMux.sv
module gteReadMux (
	input  logic                i_clk,
	input  logic                resetStatus,
	input  gtePkg::cpuReq_t     i_req,
	input  gtePkg::word_t       i_dataFile,
	input  gtePkg::word_t       i_ctrlFile,
	input  gtePkg::shadowView_t i_view,
	output gtePkg::word_t       o_dataOut
);
	import gtePkg::*;

	// One IR value to a 5-bit colour channel
	function automatic logic [4:0] colourChan(input half_t ir);
		if (ir[15]) begin
			return 5'd0;          // Negative clamps to 0
		end else if (|ir[14:12]) begin
			return 5'd31;         // 0x1000 and up saturates
		end
		return ir[11:7];
	endfunction

	logic        signExt, zeroExt;    // Promotion of incoming ID
	logic        capSign, capZero;    // Same, captured
	logic        capValid;            // Read seen since reset
	logic        capHit;              // Captured ID is a shadow register
	regId_t      capId;
	logic [1:0]  slot;
	half_t       irSel;
	logic [14:0] packedRgb;           // B:G:R, red in low bits
	word_t       shadowWord, capShadow, srcWord;

	// --------------------------------------------------------------------
	// Request side
	// --------------------------------------------------------------------
	assign signExt = i_req.id inside {REG_VZ0, REG_VZ1, REG_VZ2, [REG_IR0:REG_IR3],
		REG_R33, REG_L33, REG_LB3};
	assign zeroExt = i_req.id inside {REG_OTZ, [REG_SZ0:REG_SZ3], [REG_H:REG_ZSF4]};

	assign slot      = i_req.id[1:0];
	assign irSel     = i_view.ir[slot];
	assign packedRgb = {colourChan(i_view.ir[3]), colourChan(i_view.ir[2]),
		colourChan(i_view.ir[1])};

	always_comb begin : shadowSelect
		case (i_req.id)
			REG_IR0, REG_IR1, REG_IR2, REG_IR3: shadowWord = {{16{irSel[15]}}, irSel};
			REG_SXY0, REG_SXY1, REG_SXY2: shadowWord = {i_view.sy[slot], i_view.sx[slot]};
			REG_SXP:  shadowWord = {i_view.sy[2], i_view.sx[2]};   // Mirror, read never shifts
			REG_SZ0, REG_SZ1, REG_SZ2, REG_SZ3: shadowWord = {16'h0, i_view.sz[slot]};
			REG_RGB0, REG_RGB1, REG_RGB2: shadowWord = i_view.rgb[slot];
			REG_IRGB, REG_ORGB: shadowWord = {17'h0, packedRgb};   // Both read the packed colour
			REG_LZCR: shadowWord = {26'h0, i_view.lzcr};
			default:  shadowWord = '0;
		endcase
	end

	// --------------------------------------------------------------------
	// Capture at the read edge
	// --------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (resetStatus) begin
			capId    <= '0;
			capSign  <= 1'b0;
			capZero  <= 1'b0;
			capValid <= 1'b0;
		end else if (i_req.rd) begin
			capId    <= i_req.id;
			capSign  <= signExt;
			capZero  <= zeroExt;
			capValid <= 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_req.rd) begin
			capShadow <= shadowWord;   // Later shadow writes leave the result alone
		end
	end

	// --------------------------------------------------------------------
	// Source select and 16-bit promotion
	// --------------------------------------------------------------------
	assign capHit = capId inside {[REG_IR0:REG_RGB2], REG_IRGB, REG_ORGB, REG_LZCR};

	always_comb begin : sourceSelect
		if (!capValid) begin
			srcWord = '0;            // Nothing read yet
		end else if (capId[5]) begin
			srcWord = i_ctrlFile;
		end else if (capHit) begin
			srcWord = capShadow;
		end else begin
			srcWord = i_dataFile;
		end
	end

	always_comb begin : promote
		o_dataOut = srcWord;
		if (capSign) begin
			o_dataOut[31:16] = {16{srcWord[15]}};
		end else if (capZero) begin
			o_dataOut[31:16] = '0;
		end
	end

endmodule

// File: logic/gteRegFile.sv
module gteRegFile (
	input  logic            i_clk,

	// Read side
	input  logic            i_rd,
	input  gtePkg::regAdr_t i_rdAdr,
	output gtePkg::word_t   o_rdData,

	// Write side
	input  logic            i_wr,
	input  gtePkg::regAdr_t i_wrAdr,
	input  gtePkg::word_t   i_wrData
);
	import gtePkg::*;

	word_t mem [32];   // 32 x 32 storage

	// Nonblocking read gives old word on same-address write
	always_ff @(posedge i_clk) begin
		if (i_wr) begin
			mem[i_wrAdr] <= i_wrData;
		end
		if (i_rd) begin
			o_rdData <= mem[i_rdAdr];   // Held until next read strobe
		end
	end

endmodule

// File: logic/gteShadowRegs.sv
module gteShadowRegs (
	input  logic                i_clk,
	input  logic                resetStatus,
	input  gtePkg::cpuReq_t     i_req,
	output gtePkg::shadowView_t o_view
);
	import gtePkg::*;

	// --------------------------------------------------------------------
	// Write data slices
	// --------------------------------------------------------------------
	half_t      lowHalf;     // SX, IR, SZ source
	half_t      highHalf;    // SY source
	logic [1:0] slot;        // Entry inside a register group
	leadCnt_t   lzcsCount;   // Leading bits of the word on the bus

	assign lowHalf  = i_req.data[15:0];
	assign highHalf = i_req.data[31:16];
	assign slot     = i_req.id[1:0];   // Groups start on a 4-aligned ID

	gteLeadCount leadCount (
		.i_value (i_req.data),
		.o_count (lzcsCount)
	);

	// --------------------------------------------------------------------
	// Register update
	// --------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (resetStatus) begin
			o_view <= '0;
		end else if (i_req.wr) begin
			case (i_req.id)
				REG_IR0, REG_IR1, REG_IR2, REG_IR3: begin
					o_view.ir[slot] <= lowHalf;   // Low 16 bits only
				end
				REG_SXY0, REG_SXY1, REG_SXY2: begin
					o_view.sx[slot] <= lowHalf;    // Direct load, no shift
					o_view.sy[slot] <= highHalf;
				end
				REG_SXP: begin
					// Push, oldest entry drops out
					o_view.sx[0] <= o_view.sx[1];
					o_view.sy[0] <= o_view.sy[1];
					o_view.sx[1] <= o_view.sx[2];
					o_view.sy[1] <= o_view.sy[2];
					o_view.sx[2] <= lowHalf;
					o_view.sy[2] <= highHalf;
				end
				REG_SZ0, REG_SZ1, REG_SZ2, REG_SZ3: begin
					o_view.sz[slot] <= lowHalf;
				end
				REG_RGB0, REG_RGB1, REG_RGB2: begin
					o_view.rgb[slot] <= i_req.data;   // Full word kept
				end
				REG_LZCS: begin
					o_view.lzcr <= lzcsCount;   // LZCS word itself lives in file
				end
				default: begin
					// File-only register, nothing held here
				end
			endcase
		end
	end

endmodule

// File: tb/gteChecker.sv
module gteChecker (
	input  logic            i_clk,
	input  logic            resetStatus,
	input  gtePkg::cpuReq_t i_req,
	input  gtePkg::word_t   i_expect,
	input  gtePkg::word_t   i_dataOut,
	output int              o_errCount,
	output int              o_checkCount
);
	import gtePkg::*;

	logic   pending;          // Read sampled at the last rising edge
	regId_t pendId;
	word_t  pendExpect;       // Expected word for that read
	int     errCount   = 0;
	int     checkCount = 0;

	assign o_errCount   = errCount;
	assign o_checkCount = checkCount;

	// --------------------------------------------------------------------
	// Take the read request together with its expected word
	// --------------------------------------------------------------------
	always @(posedge i_clk) begin
		pending <= i_req.rd & ~resetStatus;
		if (i_req.rd) begin
			pendId     <= i_req.id;
			pendExpect <= i_expect;
		end
	end

	// Result is stable mid-cycle after the read edge
	always @(negedge i_clk) begin
		if (pending === 1'b1) begin
			checkCount <= checkCount + 1;
			if (i_dataOut !== pendExpect) begin
				errCount <= errCount + 1;
				$display("[ERROR] %0t: register %0d read %08h, expected %08h",
					$time, pendId, i_dataOut, pendExpect);
			end
		end
	end

endmodule

// File: tb/gteTb.sv
module gteTb;
	import gtePkg::*;

	localparam logic [1:0] OP_IDLE = 2'd0;
	localparam logic [1:0] OP_WR   = 2'd1;
	localparam logic [1:0] OP_RD   = 2'd2;

	typedef struct packed {
		logic [1:0] op;
		regId_t     id;
		word_t      data;
		word_t      expVal;   // Only used on reads
	} stimRow_t;

	logic     i_clk = 1'b0;
	logic     resetStatus;
	cpuReq_t  req;
	word_t    dataOut;
	word_t    expWord;         // Goes to the checker with the read strobe
	int       compareErrs, checksDone, totalErrs;
	int       readRows;
	int       cycleCount = 0;
	int       cycleLimit = 1000;   // Replaced once the table is built
	stimRow_t rows[$];

	always #10 i_clk = ~i_clk;

	gteCpuPort dut (
		.i_clk       (i_clk),
		.resetStatus (resetStatus),
		.i_req       (req),
		.o_dataOut   (dataOut)
	);

	gteChecker readCheck (
		.i_clk        (i_clk),
		.resetStatus  (resetStatus),
		.i_req        (req),
		.i_expect     (expWord),
		.i_dataOut    (dataOut),
		.o_errCount   (compareErrs),
		.o_checkCount (checksDone)
	);

	// --------------------------------------------------------------------
	// Reference rules
	// --------------------------------------------------------------------
	function automatic word_t signExtend(input word_t w);
		return {{16{w[15]}}, w[15:0]};
	endfunction

	function automatic word_t zeroExtend(input word_t w);
		return {16'h0, w[15:0]};
	endfunction

	// 5-bit colour channel of one IR value
	function automatic logic [4:0] irChannel(input word_t w);
		if (w[15]) begin
			return 5'd0;
		end
		if (w[14:12] != 3'b000) begin
			return 5'd31;
		end
		return w[11:7];
	endfunction

	// Shift left while the top bit still matches the sign
	function automatic int leadBits(input word_t w);
		word_t v;
		int    n;
		v = w;
		n = 0;
		while (n < 32 && v[31] == w[31]) begin
			n++;
			v = v << 1;
		end
		return n;
	endfunction

	task automatic addRow(input logic [1:0] op, input regId_t id, input word_t data,
		input word_t expVal);
		stimRow_t row;
		row.op     = op;
		row.id     = id;
		row.data   = data;
		row.expVal = expVal;
		rows.push_back(row);
		if (op == OP_RD) begin
			readRows++;
		end
	endtask

	// --------------------------------------------------------------------
	// Stimulus table
	// --------------------------------------------------------------------
	task automatic buildTable();
		word_t  r [16];
		word_t  sxp [4];
		word_t  lz [5];
		word_t  colourSet [6];
		word_t  pv, colourWord;
		regId_t promoId [6];
		foreach (r[i]) begin
			r[i] = $urandom();
		end
		foreach (sxp[i]) begin
			sxp[i] = $urandom();
		end
		promoId = '{REG_VZ0, REG_IR2, REG_R33, REG_OTZ, REG_SZ1, 6'd61};   // Last is ZSF3
		lz = '{32'h0, 32'hFFFF_FFFF, 32'h1, 32'hA5A5_0000, r[13]};
		colourSet = '{32'h0000_8000, 32'h0000_1000, 32'h0000_0A80,
			32'h0000_0FFF, 32'h0000_FFFF, 32'h0000_7000};

		// Plain file registers, ID 34 shares low address with data 2
		addRow(OP_WR, 6'd0,  r[0], '0);
		addRow(OP_WR, 6'd2,  r[1], '0);
		addRow(OP_WR, 6'd23, r[2], '0);
		addRow(OP_WR, 6'd34, r[3], '0);
		addRow(OP_WR, 6'd47, r[4], '0);
		addRow(OP_WR, 6'd63, r[5], '0);
		addRow(OP_RD, 6'd0,  '0, r[0]);
		addRow(OP_RD, 6'd23, '0, r[2]);
		addRow(OP_RD, 6'd34, '0, r[3]);
		addRow(OP_RD, 6'd47, '0, r[4]);
		addRow(OP_RD, 6'd63, '0, r[5]);
		addRow(OP_RD, 6'd2,  '0, r[1]);
		addRow(OP_WR, 6'd2,  r[6], '0);   // Right behind the read above
		addRow(OP_RD, 6'd2,  '0, r[6]);

		// Promotion, first three sign, last three zero
		for (int i = 0; i < 6; i++) begin
			pv = r[7 + i] | 32'h0000_8000;
			addRow(OP_WR, promoId[i], pv, '0);
			addRow(OP_RD, promoId[i], '0, (i < 3) ? signExtend(pv) : zeroExtend(pv));
		end

		// SXY FIFO pushes
		for (int i = 0; i < 4; i++) begin
			addRow(OP_WR, REG_SXP, sxp[i], '0);
			if (i == 2) begin
				addRow(OP_RD, REG_SXY0, '0, sxp[0]);   // Three pushes in
			end
		end
		addRow(OP_RD, REG_SXY0, '0, sxp[1]);
		addRow(OP_RD, REG_SXY1, '0, sxp[2]);
		addRow(OP_RD, REG_SXY2, '0, sxp[3]);
		addRow(OP_RD, REG_SXP,  '0, sxp[3]);

		// Lead count
		foreach (lz[i]) begin
			addRow(OP_WR, REG_LZCS, lz[i], '0);
			addRow(OP_RD, REG_LZCR, '0, word_t'(leadBits(lz[i])));
			addRow(OP_RD, REG_LZCS, '0, lz[i]);
		end

		// Colour packing, red from IR1 in low bits
		for (int s = 0; s < 2; s++) begin
			for (int c = 0; c < 3; c++) begin
				addRow(OP_WR, REG_IR1 + regId_t'(c), colourSet[3 * s + c], '0);
			end
			colourWord = {17'h0, irChannel(colourSet[3 * s + 2]),
				irChannel(colourSet[3 * s + 1]), irChannel(colourSet[3 * s])};
			addRow(OP_RD, REG_IRGB, '0, colourWord);
			addRow(OP_RD, REG_ORGB, '0, colourWord);
		end

		// Direct shadow writes
		addRow(OP_WR, REG_RGB1, r[14], '0);
		addRow(OP_WR, REG_IR0,  r[15], '0);
		addRow(OP_RD, REG_RGB1, '0, r[14]);
		addRow(OP_RD, REG_IR0,  '0, signExtend(r[15]));
		addRow(OP_IDLE, '0, '0, '0);
		addRow(OP_IDLE, '0, '0, '0);
	endtask

	// --------------------------------------------------------------------
	// Run
	// --------------------------------------------------------------------
	initial begin
		req         = '0;
		expWord     = '0;
		resetStatus = 1'b1;
		readRows    = 0;
		void'($urandom(76));
		buildTable();
		cycleLimit = 2 * rows.size() + 20;
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		resetStatus = 1'b0;
		foreach (rows[i]) begin
			req.rd   = (rows[i].op == OP_RD);
			req.wr   = (rows[i].op == OP_WR);
			req.id   = rows[i].id;
			req.data = rows[i].data;
			expWord  = rows[i].expVal;
			@(negedge i_clk);
		end
		req = '0;
		@(negedge i_clk);
		totalErrs = compareErrs + dut.asserts.failCount;
		if (checksDone != readRows) begin
			$display("Only %0d of %0d reads were checked", checksDone, readRows);
			totalErrs++;
		end
		$display("Errors: compare %0d, assertion %0d, total %0d",
			compareErrs, dut.asserts.failCount, totalErrs);
		if (totalErrs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Watchdog
	always @(posedge i_clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Run timed out after %0d cycles", cycleCount);
			$display("sim failed");
			$finish;
		end
	end

endmodule

// File: tb/gte_asserts.sv
module gteAsserts (
	input logic            i_clk,
	input logic            resetStatus,
	input gtePkg::cpuReq_t i_req,
	input gtePkg::word_t   i_dataOut
);
	import gtePkg::*;

	int   failCount = 0;   // Read by the testbench at the end
	logic rdStrobe;

	assign rdStrobe = i_req.rd;

	// At most one strobe per cycle
	strobeExclusive: assert property (@(posedge i_clk) !(i_req.rd && i_req.wr))
		else begin
			failCount = failCount + 1;
			$error("read and write strobes high in the same cycle");
		end

	// Output cleared by reset
	zeroAfterReset: assert property (@(posedge i_clk) resetStatus |=> (i_dataOut == '0))
		else begin
			failCount = failCount + 1;
			$error("read data not zero in the cycle after reset");
		end

	// Only a read moves the output
	holdWithoutRead: assert property (@(posedge i_clk) disable iff (resetStatus)
		!$past(rdStrobe) |-> $stable(i_dataOut))
		else begin
			failCount = failCount + 1;
			$error("read data changed without a read");
		end

endmodule

bind gteCpuPort gteAsserts asserts (
	.i_clk       (i_clk),
	.resetStatus (resetStatus),
	.i_req       (i_req),
	.i_dataOut   (o_dataOut)
);
